/* core_pkg.sv */
// Widths, opcode and funct constants, ALU operation codes, instruction word union
package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data and instruction word
  localparam int XLEN       = 32;
  // Register index
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  // ALU operation code
  localparam int ALU_OP_W   = 4;
  // Shift amount taken from operand B
  localparam int SHAMT_W    = 5;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and funct fields
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Alternate form, SUB instead of ADD and SRA instead of SRL
  localparam logic [6:0] F7_ALT     = 7'b0100000;

  //////////////////////////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////////////////////////

  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd9;
  // Operand B straight through, used by LUI
  localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10;

  //////////////////////////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////////////////////////

  // Same 32 bits seen as R-type or I-type
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r;
    struct packed {
      logic [11:0]           imm12;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i;
  } instr_t;

endpackage

/* register_file.sv */
// 32x32 register file, two combinational read ports, one write port, x0 hardwired to zero
`timescale 1ns/1ps

module register_file import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Read ports
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,

  // Write port from WB
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  // Storage, entry 0 is never written
  logic [XLEN-1:0] regs_q [NUM_REGS];

  //////////////////////////////////////////////////////////////////////
  // Write
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read
  //////////////////////////////////////////////////////////////////////

  // Old value during a same-cycle write
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* id_stage.sv */
// Decode stage with instruction input register, decoder, bypass muxes and ID/EX register
`timescale 1ns/1ps

module id_stage import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Instruction strobe
  input  logic                  instr_valid_i,
  input  instr_t                instr_i,

  // Register file read
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,

  // Bypass from EX
  input  logic                  ex_fwd_we_i,
  input  logic [REG_ADDR_W-1:0] ex_fwd_rd_i,
  input  logic [XLEN-1:0]       ex_fwd_data_i,

  // Bypass from WB
  input  logic                  wb_we_i,
  input  logic [REG_ADDR_W-1:0] wb_rd_i,
  input  logic [XLEN-1:0]       wb_data_i,

  // ID/EX register
  output logic                  ex_valid_o,
  output logic                  ex_we_o,
  output logic [REG_ADDR_W-1:0] ex_rd_o,
  output logic [ALU_OP_W-1:0]   ex_alu_op_o,
  output logic [XLEN-1:0]       ex_op_a_o,
  output logic [XLEN-1:0]       ex_op_b_o
);

  // Input register
  logic                instr_valid_q;
  instr_t              instr_q;

  // Decoder
  logic                dec_legal;
  logic                dec_use_imm;
  logic                dec_lui;
  logic                dec_alt;
  logic                dec_we;
  logic [ALU_OP_W-1:0] dec_alu_op;

  // Operands
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_u;
  logic [XLEN-1:0]     rs1_val;
  logic [XLEN-1:0]     rs2_val;
  logic [XLEN-1:0]     op_b;

  // funct3 to ALU operation
  // Alt picks SUB or SRA
  function automatic logic [ALU_OP_W-1:0] f3_to_alu_op(
    input logic [2:0] funct3,
    input logic       alt
  );
    logic [ALU_OP_W-1:0] op;
    case (funct3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
    endcase
    return op;
  endfunction

  // Priority EX over WB over register file
  function automatic logic [XLEN-1:0] bypass_sel(
    input logic [REG_ADDR_W-1:0] src,
    input logic [XLEN-1:0]       rf_data,
    input logic                  ex_we,
    input logic [REG_ADDR_W-1:0] ex_rd,
    input logic [XLEN-1:0]       ex_data,
    input logic                  wb_we,
    input logic [REG_ADDR_W-1:0] wb_rd,
    input logic [XLEN-1:0]       wb_data
  );
    logic [XLEN-1:0] val;
    val = rf_data;
    if (ex_we && (ex_rd != '0) && (ex_rd == src)) begin
      val = ex_data;
    end else if (wb_we && (wb_rd != '0) && (wb_rd == src)) begin
      val = wb_data;
    end
    return val;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Instruction input register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      instr_valid_q <= 1'b0;
    end else begin
      instr_valid_q <= instr_valid_i;
    end
  end

  // Payload only moves on a strobe
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      instr_q <= instr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  // funct7 of the R view overlays imm12[11:5] of the I view
  assign dec_alt = (instr_q.r.funct7 == F7_ALT);

  always_comb begin
    dec_legal   = 1'b0;
    dec_use_imm = 1'b0;
    dec_lui     = 1'b0;
    dec_alu_op  = ALU_ADD;
    case (instr_q.r.opcode)
      OPC_OP: begin
        dec_legal  = 1'b1;
        dec_alu_op = f3_to_alu_op(instr_q.r.funct3, dec_alt);
      end
      OPC_OP_IMM: begin
        dec_legal   = 1'b1;
        dec_use_imm = 1'b1;
        // No subtract form for immediates
        dec_alu_op  = f3_to_alu_op(instr_q.i.funct3,
                                   dec_alt && (instr_q.i.funct3 == F3_SRL_SRA));
      end
      OPC_LUI: begin
        dec_legal  = 1'b1;
        dec_lui    = 1'b1;
        dec_alu_op = ALU_PASS_B;
      end
      default: begin
        dec_legal = 1'b0;
      end
    endcase
  end

  // No write for x0 or unknown opcodes
  assign dec_we = instr_valid_q && dec_legal && (instr_q.r.rd != '0);

  //////////////////////////////////////////////////////////////////////
  // Operand read and bypass
  //////////////////////////////////////////////////////////////////////

  assign rf_raddr_a_o = instr_q.r.rs1;
  assign rf_raddr_b_o = instr_q.r.rs2;

  assign rs1_val = bypass_sel(instr_q.r.rs1, rf_rdata_a_i,
                              ex_fwd_we_i, ex_fwd_rd_i, ex_fwd_data_i,
                              wb_we_i, wb_rd_i, wb_data_i);
  assign rs2_val = bypass_sel(instr_q.r.rs2, rf_rdata_b_i,
                              ex_fwd_we_i, ex_fwd_rd_i, ex_fwd_data_i,
                              wb_we_i, wb_rd_i, wb_data_i);

  // Sign-extended I immediate
  assign imm_i = {{(XLEN-12){instr_q.i.imm12[11]}}, instr_q.i.imm12};
  // U immediate rebuilt from I view fields
  assign imm_u = {instr_q.i.imm12, instr_q.i.rs1, instr_q.i.funct3, 12'b0};

  always_comb begin
    if (dec_lui) begin
      op_b = imm_u;
    end else if (dec_use_imm) begin
      op_b = imm_i;
    end else begin
      op_b = rs2_val;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_valid_o <= 1'b0;
      ex_we_o    <= 1'b0;
    end else begin
      ex_valid_o <= instr_valid_q;
      ex_we_o    <= dec_we;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_rd_o     <= instr_q.r.rd;
    ex_alu_op_o <= dec_alu_op;
    ex_op_a_o   <= rs1_val;
    ex_op_b_o   <= op_b;
  end

endmodule

/* ex_stage.sv */
// Execute stage: ALU, EX bypass outputs, EX/WB pipeline register
`timescale 1ns/1ps

module ex_stage import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // ID/EX register
  input  logic                  ex_valid_i,
  input  logic                  ex_we_i,
  input  logic [REG_ADDR_W-1:0] ex_rd_i,
  input  logic [ALU_OP_W-1:0]   ex_alu_op_i,
  input  logic [XLEN-1:0]       ex_op_a_i,
  input  logic [XLEN-1:0]       ex_op_b_i,

  // Bypass back to decode
  output logic                  ex_fwd_we_o,
  output logic [REG_ADDR_W-1:0] ex_fwd_rd_o,
  output logic [XLEN-1:0]       ex_fwd_data_o,

  // EX/WB register
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o
);

  logic [XLEN-1:0]    alu_result;
  logic [SHAMT_W-1:0] shamt;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  // Low bits of B only
  assign shamt = ex_op_b_i[SHAMT_W-1:0];

  always_comb begin
    case (ex_alu_op_i)
      ALU_ADD:    alu_result = ex_op_a_i + ex_op_b_i;
      ALU_SUB:    alu_result = ex_op_a_i - ex_op_b_i;
      ALU_AND:    alu_result = ex_op_a_i & ex_op_b_i;
      ALU_OR:     alu_result = ex_op_a_i | ex_op_b_i;
      ALU_XOR:    alu_result = ex_op_a_i ^ ex_op_b_i;
      // Signed compare
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(ex_op_a_i) < $signed(ex_op_b_i)};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, ex_op_a_i < ex_op_b_i};
      ALU_SLL:    alu_result = ex_op_a_i << shamt;
      ALU_SRL:    alu_result = ex_op_a_i >> shamt;
      // Sign bit fills from the left
      ALU_SRA:    alu_result = $unsigned($signed(ex_op_a_i) >>> shamt);
      ALU_PASS_B: alu_result = ex_op_b_i;
      default:    alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // EX bypass
  //////////////////////////////////////////////////////////////////////

  assign ex_fwd_we_o   = ex_valid_i && ex_we_i;
  assign ex_fwd_rd_o   = ex_rd_i;
  assign ex_fwd_data_o = alu_result;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  // Strobe only for real writes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= ex_valid_i && ex_we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o   <= ex_rd_i;
    wb_data_o <= alu_result;
  end

endmodule

/* core_top.sv */
// Top level of the three-stage pipeline: decode, execute, register file and write-back ports
`timescale 1ns/1ps

module core_top import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Instruction strobe, no back-pressure
  input  logic                  instr_valid_i,
  input  instr_t                instr_i,

  // Write-back
  output logic                  wb_valid_o,
  output logic [REG_ADDR_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]       wb_data_o
);

  // Register file read
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;

  // ID/EX
  logic                  ex_valid;
  logic                  ex_we;
  logic [REG_ADDR_W-1:0] ex_rd;
  logic [ALU_OP_W-1:0]   ex_alu_op;
  logic [XLEN-1:0]       ex_op_a;
  logic [XLEN-1:0]       ex_op_b;

  // EX bypass
  logic                  ex_fwd_we;
  logic [REG_ADDR_W-1:0] ex_fwd_rd;
  logic [XLEN-1:0]       ex_fwd_data;

  // EX/WB
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  id_stage id_stage_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .rf_raddr_a_o  ( rf_raddr_a    ),
    .rf_raddr_b_o  ( rf_raddr_b    ),
    .rf_rdata_a_i  ( rf_rdata_a    ),
    .rf_rdata_b_i  ( rf_rdata_b    ),
    .ex_fwd_we_i   ( ex_fwd_we     ),
    .ex_fwd_rd_i   ( ex_fwd_rd     ),
    .ex_fwd_data_i ( ex_fwd_data   ),
    // WB result doubles as bypass
    .wb_we_i       ( wb_valid      ),
    .wb_rd_i       ( wb_rd         ),
    .wb_data_i     ( wb_data       ),
    .ex_valid_o    ( ex_valid      ),
    .ex_we_o       ( ex_we         ),
    .ex_rd_o       ( ex_rd         ),
    .ex_alu_op_o   ( ex_alu_op     ),
    .ex_op_a_o     ( ex_op_a       ),
    .ex_op_b_o     ( ex_op_b       )
  );

  ex_stage ex_stage_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ex_valid_i    ( ex_valid      ),
    .ex_we_i       ( ex_we         ),
    .ex_rd_i       ( ex_rd         ),
    .ex_alu_op_i   ( ex_alu_op     ),
    .ex_op_a_i     ( ex_op_a       ),
    .ex_op_b_i     ( ex_op_b       ),
    .ex_fwd_we_o   ( ex_fwd_we     ),
    .ex_fwd_rd_o   ( ex_fwd_rd     ),
    .ex_fwd_data_o ( ex_fwd_data   ),
    .wb_valid_o    ( wb_valid      ),
    .wb_rd_o       ( wb_rd         ),
    .wb_data_o     ( wb_data       )
  );

  //////////////////////////////////////////////////////////////////////
  // Register file, written on the edge after the WB strobe
  //////////////////////////////////////////////////////////////////////

  register_file register_file_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .we_i      ( wb_valid   ),
    .waddr_i   ( wb_rd      ),
    .wdata_i   ( wb_data    )
  );

  // Write-back ports
  assign wb_valid_o = wb_valid;
  assign wb_rd_o    = wb_rd;
  assign wb_data_o  = wb_data;

endmodule

/* core_props.sv */
// Concurrent assertions on core_top write-back timing, bound into core_top
`timescale 1ns/1ps

module core_props import core_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  input  instr_t                instr_i,
  input  logic                  wb_valid_i,
  input  logic [REG_ADDR_W-1:0] wb_rd_i
);

  // Failed assertion count
  int  fail_cnt = 0;
  // Strobed instruction that must write back
  logic kept_we;

  assign kept_we = instr_valid_i && (instr_i.r.rd != '0) &&
                   (instr_i.r.opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI});

  // Quiet in reset and one cycle beyond
  reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !wb_valid_i ##1 !wb_valid_i)
    else begin
      fail_cnt++;
      $error("wb_valid high during or just after reset");
    end

  // Fixed 3-cycle latency
  wb_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                               kept_we |-> ##3 wb_valid_i)
    else begin
      fail_cnt++;
      $error("write-back missing 3 cycles after issue");
    end

  wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  wb_valid_i |-> (wb_rd_i != '0))
    else begin
      fail_cnt++;
      $error("write-back strobe to x0");
    end

endmodule

bind core_top core_props core_props_i (
  .clk_i         ( clk_i         ),
  .rst_n_i       ( rst_n_i       ),
  .instr_valid_i ( instr_valid_i ),
  .instr_i       ( instr_i       ),
  .wb_valid_i    ( wb_valid_o    ),
  .wb_rd_i       ( wb_rd_o       )
);

/* tb_core.sv */
// Testbench for core_top: stimulus file reader, instruction driver, write-back scoreboard
`timescale 1ns/1ps

module tb_core import core_pkg::*; ();

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid;
  instr_t                instr;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]       wb_data;

  // Stimulus table, one entry per instruction line
  logic [XLEN-1:0]       stim_word_q  [$];
  logic                  stim_we_q    [$];
  logic [REG_ADDR_W-1:0] stim_rd_q    [$];
  logic [XLEN-1:0]       stim_data_q  [$];
  logic                  stim_burst_q [$];
  int                    stim_line_q  [$];

  // Write-back slots in issue order, due edge and stimulus index
  int                    exp_due_q [$];
  int                    exp_idx_q [$];

  int                    edge_cnt   = 0;
  int                    value_errs = 0;
  int                    other_errs = 0;
  integer                seed       = 32'h3761_6ff6;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  core_top uut (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .instr_valid_i ( instr_valid ),
    .instr_i       ( instr       ),
    .wb_valid_o    ( wb_valid    ),
    .wb_rd_o       ( wb_rd       ),
    .wb_data_o     ( wb_data     )
  );

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                          input logic [REG_ADDR_W-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %s rd expected x%0d actual x%0d", name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %s data expected %08h actual %08h", name, exp, act);
    end
  endtask

  task automatic check_strobe(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("[ERROR] %s wb_valid expected %b actual %b", name, exp, act);
    end
  endtask

  // Source line and word of one stimulus entry
  function automatic string test_name(input int idx);
    return $sformatf("line %0d (%08h)", stim_line_q[idx], stim_word_q[idx]);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus file
  //////////////////////////////////////////////////////////////////////

  task automatic load_stimulus();
    int              fd;
    int              line_no;
    logic            burst;
    string           line;
    string           tok;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] we_f;
    logic [XLEN-1:0] rd_f;
    logic [XLEN-1:0] data_f;
    fd = $fopen("core_stimulus.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("Could not open core_stimulus.txt for reading");
      return;
    end
    line_no = 0;
    burst   = 1'b0;
    // Bounded even for a runaway file
    while (line_no < 1000) begin
      if ($fgets(line, fd) == 0) break;
      line_no++;
      if ($sscanf(line, "%s", tok) != 1) continue;
      // Comment line
      if (tok.getc(0) == 8'h23) continue;
      // Gap mode switches
      if (tok == "burst") begin
        burst = 1'b1;
        continue;
      end
      if (tok == "random") begin
        burst = 1'b0;
        continue;
      end
      if ($sscanf(line, "%h %h %h %h", word, we_f, rd_f, data_f) != 4) begin
        other_errs++;
        $display("Stimulus line %0d does not hold four hex fields", line_no);
        continue;
      end
      stim_word_q.push_back(word);
      stim_we_q.push_back(we_f[0]);
      stim_rd_q.push_back(rd_f[REG_ADDR_W-1:0]);
      stim_data_q.push_back(data_f);
      stim_burst_q.push_back(burst);
      stim_line_q.push_back(line_no);
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driver helpers
  //////////////////////////////////////////////////////////////////////

  // Strobe one instruction, slot is 3 cycles after the capture edge
  task automatic issue_instr(input int idx);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = stim_word_q[idx];
    exp_due_q.push_back(edge_cnt + 4);
    exp_idx_q.push_back(idx);
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      instr_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_due_q.size() > 0) && (cycles < 20)) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_due_q.size() > 0) begin
      other_errs++;
      $display("Timed out with %0d write-back slots still pending", exp_due_q.size());
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor, outputs are registered so pre-edge values are stable
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    int idx;
    edge_cnt = edge_cnt + 1;
    if (rst_n === 1'b1) begin
      if ((exp_due_q.size() > 0) && (exp_due_q[0] == edge_cnt)) begin
        idx = exp_idx_q.pop_front();
        void'(exp_due_q.pop_front());
        check_strobe(test_name(idx), stim_we_q[idx], wb_valid);
        if (stim_we_q[idx] && (wb_valid === 1'b1)) begin
          check_rd(test_name(idx), stim_rd_q[idx], wb_rd);
          check_data(test_name(idx), stim_data_q[idx], wb_data);
        end
      end else if (wb_valid !== 1'b0) begin
        other_errs++;
        $display("Write-back strobe at edge %0d with no instruction due", edge_cnt);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int gap;
    instr_valid = 1'b0;
    instr       = '0;
    rst_n       = 1'b0;
    load_stimulus();
    // 10 cycles in reset
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
    end
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet outputs right after reset
    for (int i = 0; i < 3; i++) begin
      check_strobe("reset_quiet", 1'b0, wb_valid);
      @(negedge clk);
    end
    foreach (stim_word_q[i]) begin
      issue_instr(i);
      gap = stim_burst_q[i] ? 0 : int'($unsigned($random(seed)) % 3);
      idle_cycles(gap);
    end
    idle_cycles(1);
    wait_drain();
    // Catch stray strobes after the last slot
    idle_cycles(4);
    $display("Errors: %0d value, %0d other, %0d assertion", value_errs, other_errs,
             uut.core_props_i.fail_cnt);
    if ((value_errs == 0) && (other_errs == 0) && (uut.core_props_i.fail_cnt == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* core_stimulus.txt */
# Columns, all hex: instruction word, expected write flag, expected rd, expected data
# Line 'burst' forces zero idle gaps, line 'random' restores random gaps of 0 to 2
random
002082B3 1 05 00000000  # add  x5, x1, x2   registers zero before first write
FF900093 1 01 FFFFFFF9  # addi x1, x0, -7
00500113 1 02 00000005  # addi x2, x0, 5
800001B7 1 03 80000000  # lui  x3, 0x80000
02100213 1 04 00000021  # addi x4, x0, 33   shift amount 1 after masking
00208533 1 0A FFFFFFFE  # add  x10, x1, x2
401105B3 1 0B 0000000C  # sub  x11, x2, x1
0020F633 1 0C 00000001  # and  x12, x1, x2
0020E6B3 1 0D FFFFFFFD  # or   x13, x1, x2
0020C733 1 0E FFFFFFFC  # xor  x14, x1, x2
0020A7B3 1 0F 00000001  # slt  x15, x1, x2
0020B833 1 10 00000000  # sltu x16, x1, x2
004118B3 1 11 0000000A  # sll  x17, x2, x4
0041D933 1 12 40000000  # srl  x18, x3, x4
4041D9B3 1 13 C0000000  # sra  x19, x3, x4
7FF08A13 1 14 000007F8  # addi x20, x1, 2047
0F00FA93 1 15 000000F0  # andi x21, x1, 0x0f0
FF016B13 1 16 FFFFFFF5  # ori  x22, x2, -16
FFF0CB93 1 17 00000006  # xori x23, x1, -1
FF80AC13 1 18 00000000  # slti x24, x1, -8
00612C93 1 19 00000001  # slti x25, x2, 6
12345D37 1 1A 12345000  # lui  x26, 0x12345
00500013 0 00 00000000  # addi x0, x0, 5    no write
0000A483 0 09 00000000  # lw   x9, 0(x1)    opcode not kept
00048DB3 1 1B 00000000  # add  x27, x9, x0
burst
00100293 1 05 00000001  # addi x5, x0, 1
00228293 1 05 00000003  # addi x5, x5, 2    distance 1
00528333 1 06 00000006  # add  x6, x5, x5   distance 1
01000393 1 07 00000010  # addi x7, x0, 16
02000413 1 08 00000020  # addi x8, x0, 32
008384B3 1 09 00000030  # add  x9, x7, x8   distances 2 and 1
06400513 1 0A 00000064  # addi x10, x0, 100
00100593 1 0B 00000001  # addi x11, x0, 1
00200613 1 0C 00000002  # addi x12, x0, 2
40C506B3 1 0D 00000062  # sub  x13, x10, x12  distances 3 and 1
00100713 1 0E 00000001  # addi x14, x0, 1
00200713 1 0E 00000002  # addi x14, x0, 2
00E707B3 1 0F 00000004  # add  x15, x14, x14  EX beats WB
00900813 1 10 00000009  # addi x16, x0, 9
00300013 0 00 00000000  # addi x0, x0, 3    never bypassed
010008B3 1 11 00000009  # add  x17, x0, x16

/* flist.f */
core_pkg.sv
register_file.sv
id_stage.sv
ex_stage.sv
core_top.sv
core_props.sv
tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_core -f flist.f

# Let assertion errors reach the testbench summary
./obj_dir/Vtb_core +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
